//--- rtl/fe_pkg.sv
package fe_pkg;

    // **************************************************
    // Default sizes, overridden from the top level.
    // **************************************************
    localparam int BLOCK_SIZE_DEF  = 8;  // Instruction slots per fetch block.
    localparam int BANK_NUM_DEF    = 4;  // Instruction buffer banks.
    localparam int BANK_DEPTH_DEF  = 4;  // Entries in each bank.
    localparam int FETCH_WIDTH_DEF = 4;  // Instructions handed to decode per cycle.

    // Width of the block index carried with every instruction.
    localparam int IDX_W = 4;

    // **************************************************
    // Opcodes and classes.
    // **************************************************
    // Major opcodes, instruction bits 6 to 0.
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Only the jump classes cut a block. Branches are kept apart for
    // prediction logic that sits beside this front end.
    typedef enum logic [1:0] {
        op_jal,
        op_jalr,
        op_branch,
        op_other
    } op_class_e;

    // State of the predecode block register.
    typedef enum logic {
        pd_empty,
        pd_held
    } pd_state_e;

endpackage

//--- rtl/predecode.sv
module predecode #(
    parameter int block_size = fe_pkg::BLOCK_SIZE_DEF
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          redirect,
    input  logic                                          full,
    input  logic                                          fetch_valid,
    input  logic [block_size-1:0][31:0]                   fetch_inst,
    input  logic [$clog2(block_size)-1:0]                 fetch_start,
    input  logic [fe_pkg::IDX_W-1:0]                      fetch_idx,
    input  logic                                          fetch_fault,
    output logic [block_size-1:0]                         pd_en,
    output logic [$clog2(block_size):0]                   pd_num,
    output logic [block_size-1:0][31:0]                   pd_inst,
    output logic [block_size-1:0][$clog2(block_size)-1:0] pd_offset,
    output logic [fe_pkg::IDX_W-1:0]                      pd_idx,
    output logic                                          pd_fault
);
    import fe_pkg::*;

    localparam int off_w = $clog2(block_size);
    localparam int num_w = off_w + 1;

    pd_state_e                   state;
    logic [block_size-1:0][31:0] blk_inst;
    logic [off_w-1:0]            blk_start;
    logic [IDX_W-1:0]            blk_idx;
    logic                        blk_fault;
    logic                        take;
    op_class_e                   cls [block_size];
    logic [block_size-1:0]       keep;
    logic [num_w-1:0]            num_sum;

    assign take = fetch_valid & ~full;

    // **************************************************
    // Block register.
    // **************************************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= pd_empty;
        end else if (redirect) begin
            state <= pd_empty;
        end else if (take) begin
            state <= pd_held;
        end else if (!full) begin
            state <= pd_empty;  // Group went into the buffer.
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            blk_inst  <= fetch_inst;
            blk_start <= fetch_start;
            blk_idx   <= fetch_idx;
            blk_fault <= fetch_fault;
        end
    end

    // **************************************************
    // Classify, mask and pack.
    // **************************************************
    always_comb begin
        for (int i = 0; i < block_size; i++) begin
            case (blk_inst[i][6:0])
                OPC_JAL:    cls[i] = op_jal;
                OPC_JALR:   cls[i] = op_jalr;
                OPC_BRANCH: cls[i] = op_branch;
                default:    cls[i] = op_other;
            endcase
        end
    end

    // A slot survives from the start slot up to and including the first jump.
    always_comb begin : keep_mask
        logic cut;
        cut     = 1'b0;
        num_sum = '0;
        for (int i = 0; i < block_size; i++) begin
            keep[i] = (i >= blk_start) && !cut;
            if (keep[i] && (cls[i] == op_jal || cls[i] == op_jalr)) begin
                cut = 1'b1;
            end
            num_sum = num_sum + num_w'(keep[i]);
        end
    end

    // Surviving slots are contiguous, so packing is a shift by the start slot.
    always_comb begin : pack
        logic [num_w-1:0] slot;
        for (int j = 0; j < block_size; j++) begin
            slot         = num_w'(blk_start) + num_w'(j);
            pd_inst[j]   = blk_inst[slot[off_w-1:0]];
            pd_offset[j] = slot[off_w-1:0];
            pd_en[j]     = (state == pd_held) && !slot[off_w] && keep[slot[off_w-1:0]];
        end
    end

    assign pd_num   = (state == pd_held) ? num_sum : '0;
    assign pd_idx   = blk_idx;
    assign pd_fault = blk_fault;

endmodule

//--- rtl/inst_buffer_bank.sv
module inst_buffer_bank #(
    parameter int width      = 32,
    parameter int wport      = 2,
    parameter int bank_depth = 4
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [wport-1:0]                           we,
    input  logic [wport-1:0][width-1:0]                din,
    input  logic [wport-1:0][$clog2(bank_depth)-1:0]   waddr,
    input  logic [$clog2(bank_depth)-1:0]              raddr,
    output logic [width-1:0]                           dout
);
    logic [width-1:0] mem [bank_depth];

    assign dout = mem[raddr];  // Read is combinational.

    // Ports never target the same entry in one cycle.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < bank_depth; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int p = 0; p < wport; p++) begin
                if (we[p]) begin
                    mem[waddr[p]] <= din[p];
                end
            end
        end
    end

endmodule

//--- rtl/inst_buffer.sv
module inst_buffer #(
    parameter int block_size  = fe_pkg::BLOCK_SIZE_DEF,
    parameter int bank_num    = fe_pkg::BANK_NUM_DEF,
    parameter int bank_depth  = fe_pkg::BANK_DEPTH_DEF,
    parameter int fetch_width = fe_pkg::FETCH_WIDTH_DEF
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           stall,
    input  logic                                           redirect,
    input  logic [block_size-1:0]                          pd_en,
    input  logic [$clog2(block_size):0]                    pd_num,
    input  logic [block_size-1:0][31:0]                    pd_inst,
    input  logic [block_size-1:0][$clog2(block_size)-1:0]  pd_offset,
    input  logic [fe_pkg::IDX_W-1:0]                       pd_idx,
    input  logic                                           pd_fault,
    output logic                                           full,
    output logic [fetch_width-1:0]                         out_en,
    output logic [fetch_width-1:0][31:0]                   out_inst,
    output logic [fetch_width-1:0][$clog2(block_size)-1:0] out_offset,
    output logic [fetch_width-1:0][fe_pkg::IDX_W-1:0]      out_idx,
    output logic [fetch_width-1:0]                         out_fault
);
    import fe_pkg::*;

    localparam int wport  = block_size / bank_num;
    localparam int cap    = bank_num * bank_depth;
    localparam int bank_w = $clog2(bank_num);
    localparam int addr_w = $clog2(bank_depth);
    localparam int ptr_w  = $clog2(cap);
    localparam int cnt_w  = ptr_w + 1;
    localparam int off_w  = $clog2(block_size);
    localparam int num_w  = off_w + 1;
    localparam int data_w = 32 + off_w + IDX_W + 1;  // Instruction, slot, index, fault.

    logic [ptr_w-1:0]                              head;
    logic [ptr_w-1:0]                              tail;
    logic [cnt_w-1:0]                              count;
    logic [cnt_w:0]                                need;
    logic [cnt_w-1:0]                              enq_num;
    logic [cnt_w-1:0]                              deq_num;
    logic [block_size-1:0][data_w-1:0]             in_data;
    logic [bank_num-1:0][wport-1:0]                bank_we;
    logic [bank_num-1:0][wport-1:0][data_w-1:0]    bank_din;
    logic [bank_num-1:0][wport-1:0][addr_w-1:0]    bank_waddr;
    logic [bank_num-1:0][data_w-1:0]               bank_dout;
    logic [bank_num-1:0]                           bank_re;
    logic [bank_num-1:0][addr_w-1:0]               rptr;
    logic [bank_num-1:0][addr_w-1:0]               wptr;
    logic [bank_num-1:0][addr_w-1:0]               wcnt;

    assign need    = {1'b0, count} + {{(cnt_w + 1 - num_w){1'b0}}, pd_num};
    assign full    = need > (cnt_w + 1)'(cap);
    assign enq_num = (pd_en[0] & ~full) ? cnt_w'(pd_num) : '0;
    assign deq_num = stall ? '0 :
                     (count >= cnt_w'(fetch_width)) ? cnt_w'(fetch_width) : count;

    for (genvar j = 0; j < block_size; j++) begin : g_in
        assign in_data[j] = {pd_fault, pd_idx, pd_offset[j], pd_inst[j]};
    end

    // **************************************************
    // Banks. Lane j lands in bank (tail + j) mod bank_num.
    // **************************************************
    for (genvar b = 0; b < bank_num; b++) begin : g_bank
        logic [bank_w-1:0] wr_lane;
        logic [bank_w-1:0] rd_lane;

        assign wr_lane = bank_w'(b) - tail[bank_w-1:0];
        assign rd_lane = bank_w'(b) - head[bank_w-1:0];

        // Lanes are contiguous, so port p writes only if ports below it do.
        for (genvar p = 0; p < wport; p++) begin : g_port
            assign bank_we[b][p]    = pd_en[p * bank_num + wr_lane] & ~full;
            assign bank_din[b][p]   = in_data[p * bank_num + wr_lane];
            assign bank_waddr[b][p] = wptr[b] + addr_w'(p);
        end

        assign bank_re[b] = ~stall && (rd_lane < fetch_width) && (count > cnt_w'(rd_lane));

        inst_buffer_bank #(
            .width      (data_w),
            .wport      (wport),
            .bank_depth (bank_depth)
        ) u_bank (
            .clk   (clk),
            .rst   (rst),
            .we    (bank_we[b]),
            .din   (bank_din[b]),
            .waddr (bank_waddr[b]),
            .raddr (rptr[b]),
            .dout  (bank_dout[b])
        );
    end

    always_comb begin
        for (int b = 0; b < bank_num; b++) begin
            wcnt[b] = '0;
            for (int p = 0; p < wport; p++) begin
                wcnt[b] = wcnt[b] + addr_w'(bank_we[b][p]);
            end
        end
    end

    // **************************************************
    // Decode lanes, read from the head bank upward.
    // **************************************************
    for (genvar i = 0; i < fetch_width; i++) begin : g_out
        logic [bank_w-1:0] rd_bank;
        logic [data_w-1:0] lane_data;

        assign rd_bank       = head[bank_w-1:0] + bank_w'(i);
        assign lane_data     = bank_dout[rd_bank];
        assign out_en[i]     = count > cnt_w'(i);
        assign out_inst[i]   = lane_data[31:0];
        assign out_offset[i] = lane_data[32 +: off_w];
        assign out_idx[i]    = lane_data[32 + off_w +: IDX_W];
        assign out_fault[i]  = lane_data[data_w-1];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            rptr  <= '0;
            wptr  <= '0;
        end else if (redirect) begin
            head  <= '0;  // Redirect drops everything queued.
            tail  <= '0;
            count <= '0;
            rptr  <= '0;
            wptr  <= '0;
        end else begin
            count <= count + enq_num - deq_num;
            head  <= head + deq_num[ptr_w-1:0];
            tail  <= tail + enq_num[ptr_w-1:0];
            for (int b = 0; b < bank_num; b++) begin
                rptr[b] <= rptr[b] + addr_w'(bank_re[b]);
                wptr[b] <= wptr[b] + wcnt[b];
            end
        end
    end

endmodule

//--- rtl/frontend_top.sv
module frontend_top #(
    parameter int block_size  = fe_pkg::BLOCK_SIZE_DEF,
    parameter int bank_num    = fe_pkg::BANK_NUM_DEF,
    parameter int bank_depth  = fe_pkg::BANK_DEPTH_DEF,
    parameter int fetch_width = fe_pkg::FETCH_WIDTH_DEF
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           fetch_valid,
    input  logic [block_size-1:0][31:0]                    fetch_inst,
    input  logic [$clog2(block_size)-1:0]                  fetch_start,
    input  logic [fe_pkg::IDX_W-1:0]                       fetch_idx,
    input  logic                                           fetch_fault,
    input  logic                                           stall,
    input  logic                                           redirect,
    output logic                                           full,
    output logic [fetch_width-1:0]                         out_en,
    output logic [fetch_width-1:0][31:0]                   out_inst,
    output logic [fetch_width-1:0][$clog2(block_size)-1:0] out_offset,
    output logic [fetch_width-1:0][fe_pkg::IDX_W-1:0]      out_idx,
    output logic [fetch_width-1:0]                         out_fault
);
    import fe_pkg::*;

    // Packed group from predecode to the buffer.
    logic [block_size-1:0]                         pd_en;
    logic [$clog2(block_size):0]                   pd_num;
    logic [block_size-1:0][31:0]                   pd_inst;
    logic [block_size-1:0][$clog2(block_size)-1:0] pd_offset;
    logic [IDX_W-1:0]                              pd_idx;
    logic                                          pd_fault;

    predecode #(
        .block_size (block_size)
    ) u_predecode (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .full        (full),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst),
        .fetch_start (fetch_start),
        .fetch_idx   (fetch_idx),
        .fetch_fault (fetch_fault),
        .pd_en       (pd_en),
        .pd_num      (pd_num),
        .pd_inst     (pd_inst),
        .pd_offset   (pd_offset),
        .pd_idx      (pd_idx),
        .pd_fault    (pd_fault)
    );

    inst_buffer #(
        .block_size  (block_size),
        .bank_num    (bank_num),
        .bank_depth  (bank_depth),
        .fetch_width (fetch_width)
    ) u_inst_buffer (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .redirect   (redirect),
        .pd_en      (pd_en),
        .pd_num     (pd_num),
        .pd_inst    (pd_inst),
        .pd_offset  (pd_offset),
        .pd_idx     (pd_idx),
        .pd_fault   (pd_fault),
        .full       (full),
        .out_en     (out_en),
        .out_inst   (out_inst),
        .out_offset (out_offset),
        .out_idx    (out_idx),
        .out_fault  (out_fault)
    );

endmodule

//--- dv/inst_buffer_checker.sv
module inst_buffer_checker #(
    parameter int block_size  = fe_pkg::BLOCK_SIZE_DEF,
    parameter int bank_num    = fe_pkg::BANK_NUM_DEF,
    parameter int bank_depth  = fe_pkg::BANK_DEPTH_DEF,
    parameter int fetch_width = fe_pkg::FETCH_WIDTH_DEF
) (
    input logic                                         clk,
    input logic                                         rst,
    input logic                                         stall,
    input logic                                         redirect,
    input logic                                         full,
    input logic [$clog2(bank_num * bank_depth):0]       count,
    input logic [fetch_width-1:0]                       out_en
);
    localparam int cap = bank_num * bank_depth;

    int err_cnt = 0;  // Failures seen, for the end-of-run summary.

    // **************************************************
    // Occupancy and output mask.
    // **************************************************
    count_bound: assert property (@(posedge clk) disable iff (!rst) count <= cap)
    else begin
        $error("buffer count %0d is above the capacity", count);
        err_cnt++;
    end

    // Valid lanes start at lane 0 with no gaps.
    out_en_thermo: assert property (@(posedge clk) disable iff (!rst)
        (out_en & (out_en + 1'b1)) == '0)
    else begin
        $error("out_en %b is not a thermometer mask", out_en);
        err_cnt++;
    end

    // **************************************************
    // Writes and redirect.
    // **************************************************
    // With decode stalled, a full buffer must not take in any entry.
    no_write_full: assert property (@(posedge clk) disable iff (!rst)
        (full && stall && !redirect) |=> count == $past(count))
    else begin
        $error("buffer count changed to %0d while full and stalled", count);
        err_cnt++;
    end

    redirect_clear: assert property (@(posedge clk) disable iff (!rst) redirect |=> count == '0)
    else begin
        $error("count %0d is not zero after a redirect", count);
        err_cnt++;
    end

endmodule

//--- dv/frontend_tb.sv
module frontend_tb;
    import fe_pkg::*;

    localparam int block_size   = BLOCK_SIZE_DEF;
    localparam int fetch_width  = FETCH_WIDTH_DEF;
    localparam int cap          = BANK_NUM_DEF * BANK_DEPTH_DEF;
    localparam int off_w        = $clog2(block_size);
    localparam int ent_w        = 1 + IDX_W + off_w + 32;  // Fault, index, slot, instruction.
    localparam int total_cycles = 260;                     // Reset plus all tests.

    logic                              clk = 1'b0;
    logic                              rst;
    logic                              fetch_valid;
    logic [block_size-1:0][31:0]       fetch_inst;
    logic [off_w-1:0]                  fetch_start;
    logic [IDX_W-1:0]                  fetch_idx;
    logic                              fetch_fault;
    logic                              stall;
    logic                              redirect;
    logic                              full;
    logic [fetch_width-1:0]            out_en;
    logic [fetch_width-1:0][31:0]      out_inst;
    logic [fetch_width-1:0][off_w-1:0] out_offset;
    logic [fetch_width-1:0][IDX_W-1:0] out_idx;
    logic [fetch_width-1:0]            out_fault;

    logic [ent_w-1:0]            mq [$];    // Entries stored in the buffer.
    logic [ent_w-1:0]            pend [$];  // Group held in the predecode register.
    logic [31:0]                 lfsr;
    logic [block_size-1:0][31:0] cur_inst;
    logic [off_w-1:0]            cur_start;
    logic [IDX_W-1:0]            cur_idx;
    logic                        cur_fault;
    logic                        blk_pending;  // Block presented but not yet accepted.
    logic                        trunc_mode;
    logic                        watch_first;
    logic                        first_seen;
    logic [IDX_W-1:0]            first_idx;
    int                          test_errs;
    int                          total_errs;
    int                          tests_failed;
    int                          chk_errs;

    frontend_top #(.block_size(block_size), .fetch_width(fetch_width)) uut (.*);

    bind inst_buffer inst_buffer_checker #(
        .block_size  (block_size),
        .bank_num    (bank_num),
        .bank_depth  (bank_depth),
        .fetch_width (fetch_width)
    ) u_checker (.*);

    always #5 clk = ~clk;

    // **************************************************
    // Stimulus helpers.
    // **************************************************
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    function automatic logic [31:0] make_inst(input op_class_e c);
        logic [24:0] hi;
        logic [6:0]  opc;
        hi = rand_bits(25);
        case (c)
            op_jal:    opc = OPC_JAL;
            op_jalr:   opc = OPC_JALR;
            op_branch: opc = OPC_BRANCH;
            default:   opc = 7'b0010011;  // ALU immediate.
        endcase
        return {hi, opc};
    endfunction

    task automatic make_block();
        int start;
        int jmp;
        if (trunc_mode) begin
            start = 1 + int'(rand_bits(3)) % (block_size - 1);
            for (int s = 0; s < block_size; s++) begin
                cur_inst[s] = make_inst(op_class_e'(2 + rand_bits(1)));  // No jumps yet.
            end
            jmp = start + int'(rand_bits(2));
            jmp = (jmp < block_size) ? jmp : block_size - 1;
            cur_inst[jmp] = make_inst(rand_bits(1) != 0 ? op_jalr : op_jal);
        end else begin
            start = int'(rand_bits(off_w));
            for (int s = 0; s < block_size; s++) begin
                cur_inst[s] = make_inst(op_class_e'(rand_bits(2)));
            end
        end
        cur_start   = off_w'(start);
        cur_idx     = cur_idx + 1'b1;
        cur_fault   = rand_bits(1) != 0;
        blk_pending = 1'b1;
    endtask

    // **************************************************
    // Reference model and checks.
    // **************************************************
    // Slots survive from the start slot through the first jal or jalr.
    task automatic expand_block();
        for (int s = cur_start; s < block_size; s++) begin
            pend.push_back({cur_fault, cur_idx, off_w'(s), cur_inst[s]});
            if (cur_inst[s][6:0] == OPC_JAL || cur_inst[s][6:0] == OPC_JALR) begin
                break;
            end
        end
    endtask

    function automatic logic model_full();
        return mq.size() + pend.size() > cap;
    endfunction

    task automatic advance_model(input logic valid, input logic st, input logic rd);
        logic was_full;
        int   deq;
        was_full = model_full();
        if (rd) begin
            mq.delete();
            pend.delete();
        end else begin
            deq = st ? 0 : ((mq.size() < fetch_width) ? mq.size() : fetch_width);
            repeat (deq) void'(mq.pop_front());
            if (!was_full) begin
                while (pend.size() > 0) begin
                    mq.push_back(pend.pop_front());
                end
                if (valid) begin
                    expand_block();
                    blk_pending = 1'b0;
                    if (watch_first && !first_seen) begin
                        first_idx  = cur_idx;
                        first_seen = 1'b1;
                    end
                end
            end
        end
    endtask

    task automatic value_mismatch(input string what, input logic [63:0] got,
                                  input logic [63:0] exp);
        $display("Fail %0t: %s is %0h, expected %0h", $time, what, got, exp);
        test_errs++;
    endtask

    task automatic note_problem(input string msg);
        $display("%s", msg);
        test_errs++;
    endtask

    task automatic check_outputs();
        int                     n;
        logic [fetch_width-1:0] exp_en;
        n = (mq.size() < fetch_width) ? mq.size() : fetch_width;
        exp_en = '0;
        for (int i = 0; i < n; i++) begin
            exp_en[i] = 1'b1;
        end
        assert (full === model_full()) else value_mismatch("full", full, model_full());
        assert (out_en === exp_en) else value_mismatch("out_en", out_en, exp_en);
        for (int i = 0; i < n; i++) begin
            assert ({out_fault[i], out_idx[i], out_offset[i], out_inst[i]} === mq[i])
            else value_mismatch($sformatf("lane %0d", i),
                                {out_fault[i], out_idx[i], out_offset[i], out_inst[i]}, mq[i]);
        end
    endtask

    // Inputs change on the rising edge, outputs are sampled on the falling edge.
    task automatic step_cycle(input logic valid, input logic st, input logic rd);
        @(posedge clk);
        if (valid && !blk_pending) begin
            make_block();
        end
        fetch_valid <= valid;
        fetch_inst  <= cur_inst;
        fetch_start <= cur_start;
        fetch_idx   <= cur_idx;
        fetch_fault <= cur_fault;
        stall       <= st;
        redirect    <= rd;
        @(negedge clk);
        check_outputs();
        advance_model(valid, st, rd);
    endtask

    task automatic close_test(input string name);
        $display("Test %-22s %s (%0d errors)", name, test_errs == 0 ? "ok" : "FAILED", test_errs);
        tests_failed += (test_errs != 0);
        total_errs   += test_errs;
        test_errs     = 0;
    endtask

    // **************************************************
    // Test sequence.
    // **************************************************
    initial begin
        logic [fetch_width*(ent_w+1)-1:0] snap;
        logic                             hit;
        lfsr         = 32'h6fb5;
        cur_idx      = '0;
        blk_pending  = 1'b0;
        trunc_mode   = 1'b0;
        watch_first  = 1'b0;
        first_seen   = 1'b0;
        test_errs    = 0;
        total_errs   = 0;
        tests_failed = 0;
        rst         <= 1'b0;
        fetch_valid <= 1'b0;
        fetch_inst  <= '0;
        fetch_start <= '0;
        fetch_idx   <= '0;
        fetch_fault <= 1'b0;
        stall       <= 1'b0;
        redirect    <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;

        repeat (80) step_cycle(rand_bits(2) != 0, 1'b0, 1'b0);
        close_test("ordered delivery");

        trunc_mode = 1'b1;
        repeat (40) step_cycle(1'b1, 1'b0, 1'b0);
        trunc_mode = 1'b0;
        close_test("start and truncation");

        hit = 1'b0;
        for (int i = 0; i < 40 && !hit; i++) begin
            step_cycle(1'b1, 1'b1, 1'b0);
            hit = full;
        end
        repeat (4) step_cycle(1'b1, 1'b1, 1'b0);
        assert (hit) else note_problem("Back-pressure: full never rose with decode stalled");
        repeat (30) step_cycle(blk_pending, 1'b0, 1'b0);
        assert (!blk_pending && mq.size() == 0 && pend.size() == 0)
        else note_problem("Back-pressure: blocks were left undelivered after the stall");
        close_test("back-pressure");

        hit = 1'b0;
        repeat (12) begin
            step_cycle(1'b1, 1'b1, 1'b0);
            if (hit) begin
                assert ({out_en, out_fault, out_idx, out_offset, out_inst} === snap)
                else note_problem($sformatf("Fail %0t: lane outputs changed under stall", $time));
            end else if (&out_en) begin
                snap = {out_en, out_fault, out_idx, out_offset, out_inst};
                hit  = 1'b1;
            end
        end
        assert (hit) else note_problem("Stall hold: the output lanes never filled");
        repeat (20) step_cycle(blk_pending, 1'b0, 1'b0);
        close_test("stall hold");

        repeat (6) step_cycle(1'b1, 1'b1, 1'b0);
        step_cycle(1'b0, 1'b1, 1'b1);
        watch_first = 1'b1;
        step_cycle(1'b1, 1'b0, 1'b0);
        assert (out_en == '0) else value_mismatch("out_en after redirect", out_en, 0);
        hit = 1'b0;
        repeat (20) begin
            step_cycle(1'b1, 1'b0, 1'b0);
            if (!hit && out_en[0]) begin
                hit = 1'b1;
                assert (first_seen && out_idx[0] == first_idx)
                else value_mismatch("first index after redirect", out_idx[0], first_idx);
            end
        end
        assert (hit) else note_problem("Redirect: nothing was delivered after the pulse");
        close_test("redirect");

        chk_errs = uut.u_inst_buffer.u_checker.err_cnt;
        $display("Tests run 5, tests failed %0d, check errors %0d, assertion errors %0d",
                 tests_failed, total_errs, chk_errs);
        if (tests_failed == 0 && chk_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(total_cycles * 20 * 10);
        $display("Watchdog: the run did not finish within %0d cycles", total_cycles * 20);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- list.f
rtl/fe_pkg.sv
rtl/predecode.sv
rtl/inst_buffer_bank.sv
rtl/inst_buffer.sv
rtl/frontend_top.sv
dv/inst_buffer_checker.sv
dv/frontend_tb.sv

//--- Bender.yml
package:
  name: frontend

sources:
  - rtl/fe_pkg.sv
  - rtl/predecode.sv
  - rtl/inst_buffer_bank.sv
  - rtl/inst_buffer.sv
  - rtl/frontend_top.sv
  - target: simulation
    files:
      - dv/inst_buffer_checker.sv
      - dv/frontend_tb.sv
